// ==== build.f ====
source/i2c_pkg.sv
source/i2c_bus_sampler.sv
source/i2c_byte_shifter.sv
source/byte_ram.sv
source/i2c_target_fsm.sv
source/i2c_target_top.sv
verification/i2c_target_tb.sv

// ==== Makefile ====
OBJ_DIR = obj_dir
SIM     = $(OBJ_DIR)/i2c_target_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module i2c_target_tb --Mdir $(OBJ_DIR) -o i2c_target_tb -f build.f

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/i2c_target_tb.sv ====
`timescale 1ns/1ps

module i2c_target_tb;

    import i2c_pkg::*;

    localparam int QTR          = 10;     // clk_in cycles per quarter bit
    localparam int IDLE_TIMEOUT = 200;

    logic      clk_in;
    logic      rstn;
    logic      scl;
    logic      sda_m;                     // master side, 0 pulls the line
    logic      sda_bus;
    logic      sda_drive_low;
    logic      int_o;

    byte_t     model_mem [MEM_DEPTH];     // expected register contents
    mem_addr_t model_ptr;
    logic      model_int;
    mem_addr_t base_addr;

    assign sda_bus = sda_m & ~sda_drive_low;   // wired-and of both sides

    i2c_target_top i_dut (
        .clk_in        (clk_in),
        .rstn          (rstn),
        .scl           (scl),
        .sda_in        (sda_bus),
        .sda_drive_low (sda_drive_low),
        .int_o         (int_o)
    );

    always #10 clk_in = ~clk_in;

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk_in);
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "sda level mismatch");
        end
    endtask

    task automatic check_int(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "interrupt mismatch");
        end
    endtask

    // target must have let go of sda before a new start
    task automatic wait_bus_free();
        int cnt;
        cnt = 0;
        while (sda_drive_low !== 1'b0 && cnt < IDLE_TIMEOUT) begin
            cnt++;
            @(posedge clk_in);
        end
        if (sda_drive_low !== 1'b0) begin
            $display("timeout: the target never released sda before a start");
            $display("TEST FAIL");
            $fatal(1, "bus stuck low");
        end
    endtask

    // one bus clock, line level is taken in the middle of scl high
    task automatic send_bit(input logic b, output logic seen);
        sda_m <= b;
        wait_cycles(QTR);
        scl <= 1'b1;
        wait_cycles(QTR);
        seen = sda_bus;
        wait_cycles(QTR);
        scl <= 1'b0;
        wait_cycles(QTR);
    endtask

    task automatic start_cond();
        if (!scl) begin                   // repeated start, bring scl up first
            sda_m <= 1'b1;
            wait_cycles(QTR);
            scl <= 1'b1;
            wait_cycles(QTR);
        end
        sda_m <= 1'b0;
        wait_cycles(QTR);
        scl <= 1'b0;
        wait_cycles(QTR);
    endtask

    task automatic stop_cond();
        sda_m <= 1'b0;
        wait_cycles(QTR);
        scl <= 1'b1;
        wait_cycles(QTR);
        sda_m <= 1'b1;
        wait_cycles(QTR);
    endtask

    task automatic write_byte(input byte_t b, output logic ack);
        logic line;
        for (int i = BYTE_W - 1; i >= 0; i--) begin
            send_bit(b[i], line);
        end
        send_bit(1'b1, ack);              // released for the target's ack
    endtask

    task automatic read_byte(input logic nack, output byte_t data);
        logic bit_val;
        logic line;
        data = '0;
        for (int i = 0; i < BYTE_W; i++) begin
            send_bit(1'b1, bit_val);
            data = {data[BYTE_W-2:0], bit_val};
        end
        send_bit(nack, line);
    endtask

    // pointer rule of the model, wrap from the top sets the interrupt
    task automatic model_advance();
        if (model_ptr == mem_addr_t'(MEM_DEPTH - 1)) begin
            model_int = 1'b1;
        end
        model_ptr = model_ptr + mem_addr_t'(1);
    endtask

    task automatic open_write(input mem_addr_t word);
        logic ack;
        wait_bus_free();
        start_cond();
        write_byte({TARGET_ADDR, 1'b0}, ack);
        check_ack(ack, 1'b0, "address ack, write");
        write_byte(word, ack);
        check_ack(ack, 1'b0, "word address ack");
        model_ptr = word;                 // first written byte is the pointer
    endtask

    task automatic write_burst(input mem_addr_t word, input byte_t data[$]);
        logic ack;
        open_write(word);
        foreach (data[i]) begin
            write_byte(data[i], ack);
            check_ack(ack, 1'b0, "data byte ack");
            model_mem[model_ptr] = data[i];
            model_advance();
        end
        stop_cond();
    endtask

    // set pointer, repeated start, read n bytes and nack the last
    task automatic read_burst(input mem_addr_t word, input int n);
        logic  ack;
        byte_t got;
        open_write(word);
        start_cond();
        write_byte({TARGET_ADDR, 1'b1}, ack);
        check_ack(ack, 1'b0, "address ack, read");
        for (int i = 0; i < n; i++) begin
            read_byte(i == n - 1, got);
            check_byte(got, model_mem[model_ptr], "read data");
            model_advance();
        end
        stop_cond();
    endtask

    task automatic test_reset_state();
        check_int(int_o, 1'b0, "int_o after reset");
        check_ack(sda_drive_low, 1'b0, "sda_drive_low on idle bus");
    endtask

    task automatic test_wrong_address();
        logic      ack;
        bus_addr_t other;
        byte_t     data[$];
        other = TARGET_ADDR ^ 7'h05;
        wait_bus_free();
        start_cond();
        write_byte({other, 1'b0}, ack);
        check_ack(ack, 1'b1, "ack for a foreign address");
        stop_cond();
        data.push_back(byte_t'($urandom));
        write_burst(8'h08, data);         // the next transfer must still work
        read_burst(8'h08, 1);
        check_int(int_o, model_int, "int_o after short transfer");
    endtask

    task automatic test_write_burst();
        byte_t data[$];
        base_addr = 8'h20 + mem_addr_t'($urandom % 128);
        for (int i = 0; i < 6; i++) begin
            data.push_back(byte_t'($urandom));
        end
        write_burst(base_addr, data);
        read_burst(base_addr, 6);
        check_int(int_o, model_int, "int_o after burst");
    endtask

    task automatic test_pointer_then_read();
        read_burst(base_addr + mem_addr_t'(2), 3);
        check_int(int_o, model_int, "int_o after pointer read");
    endtask

    task automatic test_wrap_interrupt();
        byte_t data[$];
        for (int i = 0; i < 4; i++) begin
            data.push_back(byte_t'($urandom));
        end
        write_burst(8'hfe, data);         // lands at fe, ff, 00, 01
        check_int(int_o, 1'b1, "int_o after pointer wrap");
        read_burst(8'hfe, 4);
        check_int(int_o, 1'b1, "int_o still set");
    endtask

    task automatic test_stop_mid_byte();
        logic  line;
        byte_t partial;
        partial = ~model_mem[base_addr];  // any store would show up
        open_write(base_addr);
        for (int i = BYTE_W - 1; i >= BYTE_W - 4; i--) begin
            send_bit(partial[i], line);
        end
        stop_cond();
        read_burst(base_addr, 1);
    endtask

    initial begin
        clk_in    = 1'b0;
        rstn      = 1'b0;
        scl       = 1'b1;
        sda_m     = 1'b1;
        model_ptr = '0;
        model_int = 1'b0;
        base_addr = '0;
        void'($urandom(32'hb542));

        wait_cycles(10);
        rstn <= 1'b1;
        wait_cycles(5);

        test_reset_state();
        test_wrong_address();
        test_write_burst();
        test_pointer_then_read();
        test_wrap_interrupt();
        test_stop_mid_byte();

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== source/i2c_target_top.sv ====
`timescale 1ns/1ps

module i2c_target_top (
    input  logic clk_in,
    input  logic rstn,
    input  logic scl,
    input  logic sda_in,
    output logic sda_drive_low,
    output logic int_o
);

    import i2c_pkg::*;

    logic      scl_rise;
    logic      scl_fall;
    logic      start_det;
    logic      stop_det;
    logic      sda_sync;
    logic      capture_en;
    logic      tx_load;
    logic      tx_bit;
    logic      drive_ack;
    logic      drive_data;
    logic      ram_we;
    bit_idx_t  tx_bit_idx;
    byte_t     rx_byte;
    byte_t     ram_rdata;
    byte_t     ram_wdata;
    mem_addr_t ram_addr;

    i2c_bus_sampler i_sampler (
        .clk_in    (clk_in),
        .rstn      (rstn),
        .scl       (scl),
        .sda_in    (sda_in),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .start_det (start_det),
        .stop_det  (stop_det),
        .sda_sync  (sda_sync)
    );

    i2c_byte_shifter i_shifter (
        .clk_in     (clk_in),
        .rstn       (rstn),
        .capture_en (capture_en),
        .sda_sync   (sda_sync),
        .tx_load    (tx_load),
        .tx_byte    (ram_rdata),
        .tx_bit_idx (tx_bit_idx),
        .rx_byte    (rx_byte),
        .tx_bit     (tx_bit)
    );

    i2c_target_fsm i_fsm (
        .clk_in     (clk_in),
        .rstn       (rstn),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_det  (start_det),
        .stop_det   (stop_det),
        .sda_sync   (sda_sync),
        .rx_byte    (rx_byte),
        .ram_rdata  (ram_rdata),
        .capture_en (capture_en),
        .tx_load    (tx_load),
        .tx_bit_idx (tx_bit_idx),
        .drive_ack  (drive_ack),
        .drive_data (drive_data),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .int_o      (int_o)
    );

    byte_ram i_ram (
        .clk_in    (clk_in),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    // open drain, only ever pull low
    assign sda_drive_low = drive_ack | (drive_data & ~tx_bit);

endmodule

// ==== source/i2c_target_fsm.sv ====
`timescale 1ns/1ps

module i2c_target_fsm (
    input  logic                clk_in,
    input  logic                rstn,
    input  logic                scl_rise,
    input  logic                scl_fall,
    input  logic                start_det,
    input  logic                stop_det,
    input  logic                sda_sync,
    input  i2c_pkg::byte_t      rx_byte,
    input  i2c_pkg::byte_t      ram_rdata,
    output logic                capture_en,
    output logic                tx_load,
    output i2c_pkg::bit_idx_t   tx_bit_idx,
    output logic                drive_ack,
    output logic                drive_data,
    output logic                ram_we,
    output i2c_pkg::mem_addr_t  ram_addr,
    output i2c_pkg::byte_t      ram_wdata,
    output logic                int_o
);

    import i2c_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_addr_ack,
        st_write,
        st_write_ack,
        st_read,
        st_read_ack
    } fsm_state_t;

    fsm_state_t state;
    bit_idx_t   bit_cnt;
    bus_addr_t  rx_addr;
    mem_addr_t  ptr;
    logic       rw;           // 1 = read transfer
    logic       ack_on;
    logic       ptr_set;      // word pointer written in this transfer
    logic       wr_pending;   // full write byte in rx_byte
    logic       addr_match;
    logic       last_bit;
    logic       store_byte;
    logic       read_done;
    logic       int_reg;

    assign rx_addr    = rx_byte[BYTE_W-1:1];
    assign addr_match = (rx_addr == TARGET_ADDR);
    assign last_bit   = (bit_cnt == bit_idx_t'(BYTE_W - 1));

    assign store_byte = wr_pending && ptr_set;
    assign read_done  = (state == st_read) && scl_fall && last_bit;

    assign capture_en = scl_rise && (state == st_addr || state == st_write);
    assign tx_bit_idx = bit_cnt;
    assign drive_ack  = ack_on;
    assign drive_data = (state == st_read);
    assign ram_we     = store_byte;
    assign ram_addr   = ptr;
    assign ram_wdata  = rx_byte;
    assign int_o      = int_reg;

    always_ff @(posedge clk_in or negedge rstn) begin
        if (!rstn) begin
            state      <= st_idle;
            bit_cnt    <= '0;
            rw         <= 1'b0;
            ack_on     <= 1'b0;
            ptr_set    <= 1'b0;
            wr_pending <= 1'b0;
            tx_load    <= 1'b0;
        end else begin
            wr_pending <= 1'b0;
            tx_load    <= 1'b0;
            if (wr_pending) begin
                ptr_set <= 1'b1;
            end

            if (start_det) begin          // repeated start too
                state   <= st_addr;
                bit_cnt <= '0;
                ack_on  <= 1'b0;
                ptr_set <= 1'b0;
            end else if (stop_det) begin  // partial byte is dropped
                state  <= st_idle;
                ack_on <= 1'b0;
            end else begin
                case (state)
                    st_idle: begin
                        bit_cnt <= '0;
                    end
                    st_addr, st_write: begin
                        if (scl_rise) begin
                            if (last_bit) begin
                                bit_cnt <= '0;
                                if (state == st_addr) begin
                                    state <= st_addr_ack;
                                end else begin
                                    state      <= st_write_ack;
                                    wr_pending <= 1'b1;
                                end
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    st_addr_ack: begin
                        if (!ack_on && !addr_match) begin
                            state <= st_idle;     // not ours, stay silent
                        end else if (scl_fall) begin
                            if (!ack_on) begin
                                ack_on  <= 1'b1;
                                rw      <= rx_byte[0];
                                tx_load <= rx_byte[0];  // first read byte
                            end else begin
                                ack_on <= 1'b0;
                                state  <= rw ? st_read : st_write;
                            end
                        end
                    end
                    st_write_ack: begin
                        if (scl_fall) begin
                            ack_on <= !ack_on;
                            if (ack_on) begin
                                state <= st_write;
                            end
                        end
                    end
                    st_read: begin
                        if (scl_fall) begin
                            if (last_bit) begin
                                bit_cnt <= '0;
                                state   <= st_read_ack;   // release for master ack
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    st_read_ack: begin
                        if (scl_rise) begin
                            if (sda_sync) begin
                                state <= st_idle;         // nack ends the read
                            end else begin
                                tx_load <= 1'b1;          // next byte
                            end
                        end else if (scl_fall) begin
                            state <= st_read;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // word pointer and sticky wrap interrupt
    always_ff @(posedge clk_in or negedge rstn) begin
        if (!rstn) begin
            ptr     <= '0;
            int_reg <= 1'b0;
        end else if (wr_pending && !ptr_set) begin
            ptr <= rx_byte;
        end else if (store_byte || read_done) begin
            ptr <= ptr + 1'b1;
            if (ptr == '1) begin
                int_reg <= 1'b1;
            end
        end
    end

    a_drive_excl: assert property (
        @(posedge clk_in) disable iff (!rstn)
        !(drive_ack && drive_data)
    );

    // data drive only exists in st_read, the ack has to be gone too
    a_idle_quiet: assert property (
        @(posedge clk_in) disable iff (!rstn)
        (state == st_idle) |-> !drive_ack
    );

    // loaded bytes come from written memory
    a_rdata_known: assert property (
        @(posedge clk_in) disable iff (!rstn)
        tx_load |-> !$isunknown(ram_rdata)
    );

endmodule

// ==== source/byte_ram.sv ====
`timescale 1ns/1ps

module byte_ram (
    input  logic                clk_in,
    input  logic                ram_we,
    input  i2c_pkg::mem_addr_t  ram_addr,
    input  i2c_pkg::byte_t      ram_wdata,
    output i2c_pkg::byte_t      ram_rdata
);

    import i2c_pkg::*;

    byte_t mem [MEM_DEPTH];

    // single port, read data holds during a write
    always_ff @(posedge clk_in) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end else begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

// ==== source/i2c_byte_shifter.sv ====
`timescale 1ns/1ps

module i2c_byte_shifter (
    input  logic               clk_in,
    input  logic               rstn,
    input  logic               capture_en,
    input  logic               sda_sync,
    input  logic               tx_load,
    input  i2c_pkg::byte_t     tx_byte,
    input  i2c_pkg::bit_idx_t  tx_bit_idx,
    output i2c_pkg::byte_t     rx_byte,
    output logic               tx_bit
);

    import i2c_pkg::*;

    byte_t tx_shadow;

    // receive side, msb first
    always_ff @(posedge clk_in or negedge rstn) begin
        if (!rstn) begin
            rx_byte <= '0;
        end else if (capture_en) begin
            rx_byte <= {rx_byte[BYTE_W-2:0], sda_sync};
        end
    end

    // transmit copy of the memory word
    always_ff @(posedge clk_in) begin
        if (tx_load) begin
            tx_shadow <= tx_byte;
        end
    end

    // msb at index 0, inverting the low bits gives BYTE_W-1-idx
    // out of range index leaves the line released
    always_comb begin
        if (tx_bit_idx < bit_idx_t'(BYTE_W)) begin
            tx_bit = tx_shadow[~tx_bit_idx[$clog2(BYTE_W)-1:0]];
        end else begin
            tx_bit = 1'b1;
        end
    end

endmodule

// ==== source/i2c_bus_sampler.sv ====
`timescale 1ns/1ps

module i2c_bus_sampler (
    input  logic clk_in,
    input  logic rstn,
    input  logic scl,
    input  logic sda_in,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_det,
    output logic stop_det,
    output logic sda_sync
);

    logic scl_s1, scl_s2, scl_s3;
    logic sda_s1, sda_s2, sda_s3;

    // bus idles high, so the sync chain resets to 1
    always_ff @(posedge clk_in or negedge rstn) begin
        if (!rstn) begin
            scl_s1    <= 1'b1;
            scl_s2    <= 1'b1;
            scl_s3    <= 1'b1;
            sda_s1    <= 1'b1;
            sda_s2    <= 1'b1;
            sda_s3    <= 1'b1;
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
        end else begin
            scl_s1 <= scl;
            scl_s2 <= scl_s1;
            scl_s3 <= scl_s2;     // history for edges
            sda_s1 <= sda_in;
            sda_s2 <= sda_s1;
            sda_s3 <= sda_s2;

            scl_rise  <= scl_s2 & ~scl_s3;
            scl_fall  <= ~scl_s2 & scl_s3;
            start_det <= scl_s2 & sda_s3 & ~sda_s2;   // sda falls, scl high
            stop_det  <= scl_s2 & ~sda_s3 & sda_s2;   // sda rises, scl high
        end
    end

    assign sda_sync = sda_s2;

    // sda must not move on a rising scl
    a_sda_setup: assert property (
        @(posedge clk_in) disable iff (!rstn)
        !((start_det || stop_det) && scl_rise)
    );

endmodule

// ==== source/i2c_pkg.sv ====
package i2c_pkg;

    localparam int BYTE_W    = 8;
    localparam int MEM_DEPTH = 256;

    // one bus byte, also one memory word
    typedef logic [BYTE_W-1:0] byte_t;

    // word pointer into the register memory
    typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;

    // 7-bit target address as it appears on the bus
    typedef logic [6:0] bus_addr_t;

    // counts bits of a byte, 0..8
    typedef logic [3:0] bit_idx_t;

    localparam bus_addr_t TARGET_ADDR = 7'h50;

endpackage
